//--- hw/sonic_consts.svh
//********************************************************************
// bus and buffer widths, buffer depth, mdc divider
// CSR word addresses of the MDIO controller
//********************************************************************
`ifndef SONIC_CONSTS_SVH
`define SONIC_CONSTS_SVH

`define SONIC_DATA_W      32   // bus word width
`define SONIC_ADDR_W      6    // word address, also transfer length
`define SONIC_FIFO_DEPTH  8    // user buffer words
`define SONIC_FIFO_AW     3    // buffer pointer bits
`define SONIC_FIFO_CW     4    // occupancy bits, holds 0..depth
`define SONIC_MDC_HALF    4    // clk cycles per mdc half period

`define SONIC_CSR_CTRL    6'd0 // launches a frame
`define SONIC_CSR_WDATA   6'd1 // write data, bits 15:0
`define SONIC_CSR_RDATA   6'd2 // captured read data
`define SONIC_CSR_STATUS  6'd3 // bit 0 busy

`endif

//--- hw/sonic_bus_pkg.sv
//********************************************************************
// transfer control, bus request and response structs
// master FSM states
//********************************************************************
`include "sonic_consts.svh"

package sonic_bus_pkg;

	typedef struct packed {
		logic                     mode;           // 0 read, 1 write
		logic                     fixed_location; // same address every word
		logic [`SONIC_ADDR_W-1:0] base;           // first word address
		logic [`SONIC_ADDR_W-1:0] length;         // words to move
	} xfer_ctrl_t;

	typedef struct packed {
		logic [`SONIC_ADDR_W-1:0] address;   // word address
		logic                     read;
		logic                     write;
		logic [`SONIC_DATA_W-1:0] writedata;
	} avm_req_t;

	typedef struct packed {
		logic [`SONIC_DATA_W-1:0] readdata;
		logic                     readdatavalid; // one cycle after accept
		logic                     waitrequest;   // stalls the current strobe
	} avm_rsp_t;

	typedef enum logic [1:0] {
		IDLE,  // waiting for go
		READ,  // issuing reads
		DRAIN, // last read accepted, data pending
		WRITE  // issuing writes
	} xfer_state_e;

endpackage : sonic_bus_pkg

//--- hw/sonic_mdio_pkg.sv
//********************************************************************
// Clause 22 opcodes, frame command and pin structs, shifter states
//********************************************************************

package sonic_mdio_pkg;

	typedef enum logic [1:0] {
		MDIO_WRITE = 2'b01,
		MDIO_READ  = 2'b10
	} mdio_op_e;

	typedef struct packed {
		mdio_op_e    op;
		logic [4:0]  phy_addr;
		logic [4:0]  reg_addr;
		logic [15:0] wdata;    // ignored for reads
	} mdio_cmd_t;

	typedef struct packed {
		logic mdc;
		logic mdio_out;
		logic mdio_oen; // high while we drive mdio
	} mdio_pins_t;

	typedef enum logic {
		IDLE,
		SHIFT
	} shift_state_e;

endpackage : sonic_mdio_pkg

//--- hw/sonic_user_fifo.sv
//********************************************************************
// synchronous word buffer, head shown combinationally
//********************************************************************
`timescale 1ns/1ps
`include "sonic_consts.svh"

module sonic_user_fifo (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      push,
	input  logic [`SONIC_DATA_W-1:0]  push_data,
	input  logic                      pop,
	output logic [`SONIC_DATA_W-1:0]  pop_data,
	output logic                      empty,
	output logic                      full,
	output logic [`SONIC_FIFO_CW-1:0] count
);

	logic [`SONIC_DATA_W-1:0]  mem [`SONIC_FIFO_DEPTH];
	logic [`SONIC_FIFO_AW-1:0] wr_ptr;
	logic [`SONIC_FIFO_AW-1:0] rd_ptr;
	logic                      do_push;
	logic                      do_pop;

	assign full     = (count == `SONIC_FIFO_CW'(`SONIC_FIFO_DEPTH));
	assign empty    = (count == '0);
	assign do_push  = push && !full; // dropped when full
	assign do_pop   = pop && !empty; // dropped when empty
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule : sonic_user_fifo

//--- hw/sonic_master_ctrl.sv
//********************************************************************
// custom bus master FSM, reads into and writes out of user buffers
//********************************************************************
`timescale 1ns/1ps
`include "sonic_consts.svh"

module sonic_master_ctrl import sonic_bus_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  xfer_ctrl_t                control_req,
	input  logic                      control_go,
	output logic                      control_done,
	output logic                      control_early_done,
	output avm_req_t                  avm_req,
	input  avm_rsp_t                  avm_rsp,
	output logic                      rd_push,
	input  logic [`SONIC_FIFO_CW-1:0] rd_count,
	output logic                      wr_pop,
	input  logic                      wr_empty,
	input  logic [`SONIC_DATA_W-1:0]  wr_data
);

	xfer_state_e              state;
	logic [`SONIC_ADDR_W-1:0] addr_q;
	logic [`SONIC_ADDR_W-1:0] addr_next;
	logic [`SONIC_ADDR_W-1:0] words_left; // strobes not yet accepted
	logic [`SONIC_ADDR_W-1:0] to_return;  // reads whose data is still out
	logic                     fixed_q;
	logic                     rd_outst;
	logic                     rd_issue;
	logic                     wr_issue;
	logic                     rd_acc;
	logic                     wr_acc;

	assign rd_outst  = (to_return != words_left); // one read in flight
	assign rd_issue  = (state == READ) && !rd_outst &&
		(rd_count < `SONIC_FIFO_CW'(`SONIC_FIFO_DEPTH)); // room for the reply
	assign wr_issue  = (state == WRITE) && !wr_empty; // head word is writedata
	assign rd_acc    = rd_issue && !avm_rsp.waitrequest;
	assign wr_acc    = wr_issue && !avm_rsp.waitrequest;
	assign addr_next = fixed_q ? addr_q : addr_q + 1'b1;

	assign avm_req = '{
		address:   addr_q,
		read:      rd_issue,
		write:     wr_issue,
		writedata: wr_data
	};

	assign rd_push = avm_rsp.readdatavalid && ((state == READ) || (state == DRAIN));
	assign wr_pop  = wr_acc; // pop as the slave takes the word

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state              <= IDLE;
			control_done       <= 1'b0;
			control_early_done <= 1'b0;
			addr_q             <= '0;
			words_left         <= '0;
			to_return          <= '0;
			fixed_q            <= 1'b0;
		end else begin
			control_done <= 1'b0; // single cycle pulse
			if (control_done)
				control_early_done <= 1'b0; // drops after done
			case (state)
				IDLE: begin
					if (control_go) begin
						addr_q     <= control_req.base;
						fixed_q    <= control_req.fixed_location;
						words_left <= control_req.length;
						to_return  <= control_req.length;
						if (control_req.length == '0)
							control_done <= 1'b1; // nothing to move
						else
							state <= control_req.mode ? WRITE : READ;
					end
				end
				READ: begin
					if (rd_push)
						to_return <= to_return - 1'b1;
					if (rd_acc) begin
						words_left <= words_left - 1'b1;
						addr_q     <= addr_next;
						if (words_left == 1) begin // last read taken
							state              <= DRAIN;
							control_early_done <= 1'b1;
						end
					end
				end
				DRAIN: begin
					if (rd_push) begin
						to_return <= to_return - 1'b1;
						if (to_return == 1) begin
							control_done <= 1'b1;
							state        <= IDLE;
						end
					end
				end
				WRITE: begin
					if (wr_acc) begin
						words_left <= words_left - 1'b1;
						addr_q     <= addr_next;
						if (words_left == 1) begin
							control_done <= 1'b1; // cycle after last accept
							state        <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule : sonic_master_ctrl

//--- hw/sonic_mdio_csr.sv
//********************************************************************
// MDIO controller CSR slave, CTRL WDATA RDATA STATUS
// waitrequest while a frame runs, one cycle read latency
//********************************************************************
`timescale 1ns/1ps
`include "sonic_consts.svh"

module sonic_mdio_csr import sonic_bus_pkg::*, sonic_mdio_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  avm_req_t    avm_req,
	output avm_rsp_t    avm_rsp,
	output mdio_cmd_t   cmd,
	output logic        start,
	input  logic        busy,
	input  logic        done,
	input  logic [15:0] rdata
);

	logic [`SONIC_DATA_W-1:0] ctrl_q;
	logic [`SONIC_DATA_W-1:0] wdata_q;
	logic [`SONIC_DATA_W-1:0] readdata_q;
	logic [15:0]              rdata_q;
	logic                     rvalid_q;
	logic                     start_q;
	logic                     hold;     // frame launched, running or finishing
	logic                     wr_ctrl;
	logic                     rd_rdata;
	logic                     wait_w;
	logic                     wr_acc;
	logic                     rd_acc;

	assign hold     = busy || start_q || done; // RDATA valid the cycle after done
	assign wr_ctrl  = avm_req.write && (avm_req.address == `SONIC_CSR_CTRL);
	assign rd_rdata = avm_req.read && (avm_req.address == `SONIC_CSR_RDATA);
	assign wait_w   = hold && (wr_ctrl || rd_rdata);
	assign wr_acc   = avm_req.write && !wait_w;
	assign rd_acc   = avm_req.read && !wait_w;

	assign avm_rsp = '{readdata: readdata_q, readdatavalid: rvalid_q, waitrequest: wait_w};
	assign start   = start_q;

	assign cmd = '{
		op:       mdio_op_e'(ctrl_q[27:26]),
		phy_addr: ctrl_q[25:21],
		reg_addr: ctrl_q[20:16],
		wdata:    wdata_q[15:0]
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q   <= '0;
			wdata_q  <= '0;
			rdata_q  <= '0;
			rvalid_q <= 1'b0;
			start_q  <= 1'b0;
		end else begin
			start_q  <= wr_acc && wr_ctrl; // launch one cycle after accept
			rvalid_q <= rd_acc;
			if (wr_acc) begin
				case (avm_req.address)
					`SONIC_CSR_CTRL:  ctrl_q  <= avm_req.writedata;
					`SONIC_CSR_WDATA: wdata_q <= avm_req.writedata;
					default:          ; // RDATA and STATUS read only
				endcase
			end
			if (done && (cmd.op == MDIO_READ))
				rdata_q <= rdata; // bits collected by the shifter
		end
	end

	always_ff @(posedge clk) begin
		if (rd_acc) begin
			case (avm_req.address)
				`SONIC_CSR_CTRL:   readdata_q <= ctrl_q;
				`SONIC_CSR_WDATA:  readdata_q <= wdata_q;
				`SONIC_CSR_RDATA:  readdata_q <= `SONIC_DATA_W'(rdata_q);
				`SONIC_CSR_STATUS: readdata_q <= `SONIC_DATA_W'(busy || start_q);
				default:           readdata_q <= '0;
			endcase
		end
	end

endmodule : sonic_mdio_csr

//--- hw/sonic_mdio_shifter.sv
//********************************************************************
// mdc divider and Clause 22 frame serializer
// 64 mdc periods per frame, 16 data bits captured on reads
//********************************************************************
`timescale 1ns/1ps
`include "sonic_consts.svh"

module sonic_mdio_shifter import sonic_mdio_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  mdio_cmd_t   cmd,
	input  logic        start,
	input  logic        mdio_in,
	output mdio_pins_t  mdio_pins,
	output logic        busy,
	output logic        done,
	output logic [15:0] rdata
);

	localparam int PW = $clog2(2 * `SONIC_MDC_HALF);

	shift_state_e  state;
	logic [PW-1:0] phase_q;   // clk cycle inside one mdc period
	logic [5:0]    bit_q;     // frame bit on the wire
	logic [63:0]   frame_q;
	logic [15:0]   rx_q;
	logic          read_op_q;
	logic          rise_tick; // mdc goes high after this edge
	logic          fall_tick; // mdc goes low, next bit
	logic          last_tick;

	assign rise_tick = (state == SHIFT) && (phase_q == PW'(`SONIC_MDC_HALF - 1));
	assign fall_tick = (state == SHIFT) && (phase_q == PW'(2 * `SONIC_MDC_HALF - 1));
	assign last_tick = (state == SHIFT) && (bit_q == 6'd63) &&
		(phase_q == PW'(2 * `SONIC_MDC_HALF - 2)); // done lands 64 periods after start

	assign busy  = (state == SHIFT);
	assign rdata = rx_q;

	assign mdio_pins = '{
		mdc:      busy && (phase_q >= PW'(`SONIC_MDC_HALF)),
		mdio_out: busy ? frame_q[63] : 1'b1,
		mdio_oen: busy && (!read_op_q || (bit_q < 6'd46)) // release from turnaround
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= IDLE;
			phase_q <= '0;
			bit_q   <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						state   <= SHIFT;
						phase_q <= '0;
						bit_q   <= '0;
					end
				end
				SHIFT: begin
					if (last_tick) begin
						state <= IDLE;
						done  <= 1'b1; // same edge busy falls
					end else if (fall_tick) begin
						phase_q <= '0;
						bit_q   <= bit_q + 1'b1;
					end else begin
						phase_q <= phase_q + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// preamble, ST, op, phy, reg, TA 10, data
	always_ff @(posedge clk) begin
		if (start && (state == IDLE)) begin
			frame_q   <= {32'hffff_ffff, 2'b01, cmd.op, cmd.phy_addr, cmd.reg_addr,
				2'b10, cmd.wdata};
			read_op_q <= (cmd.op == MDIO_READ);
		end else if (fall_tick) begin
			frame_q <= {frame_q[62:0], 1'b0}; // msb first on the wire
		end
		if (rise_tick && read_op_q && (bit_q >= 6'd48))
			rx_q <= {rx_q[14:0], mdio_in}; // PHY data, msb first
	end

endmodule : sonic_mdio_shifter

//--- hw/sonic_mdio_top.sv
//********************************************************************
// bus master, read and write buffers, MDIO CSR slave and shifter
//********************************************************************
`timescale 1ns/1ps
`include "sonic_consts.svh"

module sonic_mdio_top import sonic_bus_pkg::*, sonic_mdio_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  xfer_ctrl_t               control_req,
	input  logic                     control_go,
	output logic                     control_done,
	output logic                     control_early_done,
	input  logic                     user_read_buffer,
	output logic [`SONIC_DATA_W-1:0] user_buffer_output_data,
	output logic                     user_data_available,
	input  logic                     user_write_buffer,
	input  logic [`SONIC_DATA_W-1:0] user_buffer_input_data,
	output logic                     user_buffer_full,
	output mdio_pins_t               mdio_pins,
	input  logic                     mdio_in
);

	avm_req_t                  avm_req;
	avm_rsp_t                  avm_rsp;
	mdio_cmd_t                 cmd;
	logic                      start;
	logic                      busy;
	logic                      done;
	logic [15:0]               rdata;
	logic                      rd_push;
	logic                      rd_empty;
	logic [`SONIC_FIFO_CW-1:0] rd_count;
	logic                      wr_pop;
	logic                      wr_empty;
	logic [`SONIC_DATA_W-1:0]  wr_data;

	assign user_data_available = !rd_empty;

	sonic_master_ctrl master_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.control_req        (control_req),
		.control_go         (control_go),
		.control_done       (control_done),
		.control_early_done (control_early_done),
		.avm_req            (avm_req),
		.avm_rsp            (avm_rsp),
		.rd_push            (rd_push),
		.rd_count           (rd_count),
		.wr_pop             (wr_pop),
		.wr_empty           (wr_empty),
		.wr_data            (wr_data)
	);

	sonic_user_fifo rd_fifo (                    // bus to user
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (rd_push),
		.push_data (avm_rsp.readdata),           // readdata straight in
		.pop       (user_read_buffer),
		.pop_data  (user_buffer_output_data),
		.empty     (rd_empty),
		.full      (),                           // master counts room itself
		.count     (rd_count)
	);

	sonic_user_fifo wr_fifo (                    // user to bus
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (user_write_buffer),
		.push_data (user_buffer_input_data),
		.pop       (wr_pop),
		.pop_data  (wr_data),
		.empty     (wr_empty),
		.full      (user_buffer_full),
		.count     ()
	);

	sonic_mdio_csr csr_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.avm_req (avm_req),
		.avm_rsp (avm_rsp),
		.cmd     (cmd),
		.start   (start),
		.busy    (busy),
		.done    (done),
		.rdata   (rdata)
	);

	sonic_mdio_shifter shifter_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.start     (start),
		.mdio_in   (mdio_in),
		.mdio_pins (mdio_pins),
		.busy      (busy),
		.done      (done),
		.rdata     (rdata)
	);

endmodule : sonic_mdio_top

//--- test/tb_clock.sv
//********************************************************************
// free running testbench clock, 8 ns period
//********************************************************************
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #4 clk = ~clk; // half period

endmodule : tb_clock

//--- test/tb_mdio_phy.sv
//********************************************************************
// behavioral Clause 22 PHY, decodes frames on mdc rising edges
// answers reads from a register array, reports the decoded frame
//********************************************************************
`timescale 1ns/1ps

module tb_mdio_phy import sonic_mdio_pkg::*; (
	input  mdio_pins_t  pins,
	input  logic [15:0] regs [32],
	output logic        mdio_in,
	output mdio_cmd_t   last_cmd,
	output logic [6:0]  oen_release, // first bit with oen low, 64 if never
	output logic        frame_ok,    // preamble, ST and write TA as expected
	output int          frame_count
);

	logic        mdc;
	logic [63:0] sh;     // wire bits, newest at bit 0
	logic [6:0]  cnt;    // rising edges seen in this frame
	logic [6:0]  rel;
	logic        rd_op;
	mdio_cmd_t   cur;

	assign mdc = pins.mdc;

	initial begin
		mdio_in     = 1'b1; // pulled up while nobody drives
		cnt         = '0;
		rel         = 7'd64;
		rd_op       = 1'b0;
		frame_count = 0;
		frame_ok    = 1'b0;
		oen_release = 7'd64;
		last_cmd    = '0;
	end

	always @(posedge mdc) begin
		if (cnt == 7'd0)
			rel = 7'd64; // new frame
		if (!pins.mdio_oen && (rel == 7'd64))
			rel = cnt;
		sh  = {sh[62:0], pins.mdio_out};
		cnt = cnt + 1'b1;
		if (cnt == 7'd46) begin // op, phy and reg all in
			cur.op       = mdio_op_e'(sh[11:10]);
			cur.phy_addr = sh[9:5];
			cur.reg_addr = sh[4:0];
			rd_op        = (sh[11:10] == 2'b10);
		end
		if (cnt == 7'd64) begin
			cur.wdata   = rd_op ? regs[cur.reg_addr] : sh[15:0]; // read frames report our answer
			frame_ok    = (sh[63:32] == '1) && (sh[31:30] == 2'b01) &&
				(rd_op || (sh[17:16] == 2'b10));
			last_cmd    = cur;
			oen_release = rel;
			frame_count = frame_count + 1;
			cnt         = '0;
		end
	end

	// drive on the falling edge so the controller samples a settled bit
	always @(negedge mdc) begin
		if (rd_op && (cnt == 7'd47))
			mdio_in = 1'b0; // second TA bit
		else if (rd_op && (cnt >= 7'd48) && (cnt < 7'd64))
			mdio_in = regs[cur.reg_addr][4'(7'd63 - cnt)]; // msb first
		else
			mdio_in = 1'b1;
	end

endmodule : tb_mdio_phy

//--- test/tb_sonic_mdio.sv
//********************************************************************
// directed tests of the MDIO subsystem, compare tasks, watchdog
//********************************************************************
`timescale 1ns/1ps
`include "sonic_consts.svh"

module tb_sonic_mdio import sonic_bus_pkg::*, sonic_mdio_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000; // six tests, up to two 512 cycle frames each, margin

	logic                     clk;
	logic                     rst_n;
	xfer_ctrl_t               control_req;
	logic                     control_go;
	logic                     control_done;
	logic                     control_early_done;
	logic                     user_read_buffer;
	logic [`SONIC_DATA_W-1:0] user_buffer_output_data;
	logic                     user_data_available;
	logic                     user_write_buffer;
	logic [`SONIC_DATA_W-1:0] user_buffer_input_data;
	logic                     user_buffer_full;
	mdio_pins_t               mdio_pins;
	logic                     mdio_in;
	logic [15:0]              phy_regs [32];
	mdio_cmd_t                phy_cmd;      // last frame the PHY decoded
	logic [6:0]               oen_release;
	logic                     frame_ok;
	int                       frame_count;
	int                       errors;
	int                       checks;
	int                       cycles;
	logic                     early_seen;   // early_done before done in last run_xfer
	logic [`SONIC_DATA_W-1:0] got_words [$];
	logic [`SONIC_DATA_W-1:0] wdata_last;   // expected CSR contents
	logic [`SONIC_DATA_W-1:0] ctrl_last;
	logic [`SONIC_DATA_W-1:0] rdata_last;

	tb_clock clock_i (.clk(clk));

	tb_mdio_phy phy_i (
		.pins        (mdio_pins),
		.regs        (phy_regs),
		.mdio_in     (mdio_in),
		.last_cmd    (phy_cmd),
		.oen_release (oen_release),
		.frame_ok    (frame_ok),
		.frame_count (frame_count)
	);

	sonic_mdio_top sonic_mdio_top_i (
		.clk                     (clk),
		.rst_n                   (rst_n),
		.control_req             (control_req),
		.control_go              (control_go),
		.control_done            (control_done),
		.control_early_done      (control_early_done),
		.user_read_buffer        (user_read_buffer),
		.user_buffer_output_data (user_buffer_output_data),
		.user_data_available     (user_data_available),
		.user_write_buffer       (user_write_buffer),
		.user_buffer_input_data  (user_buffer_input_data),
		.user_buffer_full        (user_buffer_full),
		.mdio_pins               (mdio_pins),
		.mdio_in                 (mdio_in)
	);

	task automatic check_word(input string what, input logic [`SONIC_DATA_W-1:0] got,
		input logic [`SONIC_DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cmd(input string what, input mdio_cmd_t got, input mdio_cmd_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display({"FAILED at time %0t: %s, got op %b phy %h reg %h data %h,",
				" expected op %b phy %h reg %h data %h"},
				$time, what, got.op, got.phy_addr, got.reg_addr, got.wdata,
				exp.op, exp.phy_addr, exp.reg_addr, exp.wdata);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at time %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	// CTRL word holds op in 27:26, phy in 25:21, reg in 20:16
	function automatic logic [`SONIC_DATA_W-1:0] make_ctrl(input mdio_op_e op,
		input logic [4:0] pa, input logic [4:0] ra);
		return {4'h0, op, pa, ra, 16'h0000};
	endfunction

	task automatic push_words(input logic [`SONIC_DATA_W-1:0] words [$]);
		foreach (words[i]) begin
			@(posedge clk);
			user_write_buffer      <= 1'b1; // one word per cycle
			user_buffer_input_data <= words[i];
		end
		@(posedge clk);
		user_write_buffer <= 1'b0;
	endtask

	task automatic run_xfer(input logic is_write, input logic fixed_loc,
		input logic [`SONIC_ADDR_W-1:0] base, input logic [`SONIC_ADDR_W-1:0] len);
		@(posedge clk);
		control_req <= '{mode: is_write, fixed_location: fixed_loc, base: base, length: len};
		control_go  <= 1'b1;
		@(posedge clk);
		control_go <= 1'b0;
		early_seen = 1'b0;
		@(negedge clk);
		while (!control_done) begin
			if (control_early_done)
				early_seen = 1'b1;
			@(negedge clk);
		end
	endtask

	task automatic pop_words(input int n);
		got_words.delete();
		repeat (n) begin
			@(negedge clk);
			check_flag("data available before pop", user_data_available, 1'b1);
			got_words.push_back(user_buffer_output_data); // head shows before the pop
			@(posedge clk);
			user_read_buffer <= 1'b1;
			@(posedge clk);
			user_read_buffer <= 1'b0;
		end
	endtask

	task automatic wait_frames(input int n);
		while (frame_count < n)
			@(negedge clk);
	endtask

	task automatic reset_state();
		@(negedge clk);
		check_flag("control_done after reset", control_done, 1'b0);
		check_flag("control_early_done after reset", control_early_done, 1'b0);
		check_flag("user_data_available after reset", user_data_available, 1'b0);
		check_flag("user_buffer_full after reset", user_buffer_full, 1'b0);
		check_flag("mdc after reset", mdio_pins.mdc, 1'b0);
		check_flag("mdio_oen after reset", mdio_pins.mdio_oen, 1'b0);
	endtask

	task automatic mdio_write_frame();
		logic [`SONIC_DATA_W-1:0] q [$];
		logic [4:0]               pa;
		logic [4:0]               ra;
		mdio_cmd_t                exp_cmd;
		pa         = 5'($urandom);
		ra         = 5'($urandom);
		wdata_last = $urandom;
		ctrl_last  = make_ctrl(MDIO_WRITE, pa, ra);
		q.push_back(wdata_last);
		q.push_back(ctrl_last);
		push_words(q);
		run_xfer(1'b1, 1'b0, `SONIC_CSR_WDATA, 6'd1); // data first, CTRL launches
		run_xfer(1'b1, 1'b0, `SONIC_CSR_CTRL, 6'd1);
		wait_frames(1);
		exp_cmd.op       = MDIO_WRITE;
		exp_cmd.phy_addr = pa;
		exp_cmd.reg_addr = ra;
		exp_cmd.wdata    = wdata_last[15:0];
		check_cmd("write frame fields", phy_cmd, exp_cmd);
		check_flag("write frame preamble, ST and TA", frame_ok, 1'b1);
		check_flag("mdio_oen high through write frame", oen_release == 7'd64, 1'b1);
	endtask

	task automatic mdio_read_frame();
		logic [`SONIC_DATA_W-1:0] q [$];
		logic [4:0]               pa;
		logic [4:0]               ra;
		mdio_cmd_t                exp_cmd;
		pa        = 5'($urandom);
		ra        = 5'($urandom);
		ctrl_last = make_ctrl(MDIO_READ, pa, ra);
		q.push_back(ctrl_last);
		push_words(q);
		run_xfer(1'b1, 1'b0, `SONIC_CSR_CTRL, 6'd1);
		run_xfer(1'b0, 1'b1, `SONIC_CSR_RDATA, 6'd1); // stalls on waitrequest
		check_flag("RDATA read held until the frame ended", frame_count == 2, 1'b1);
		rdata_last = {16'h0000, phy_regs[ra]};
		pop_words(1);
		check_word("RDATA after read frame", got_words[0], rdata_last);
		exp_cmd.op       = MDIO_READ;
		exp_cmd.phy_addr = pa;
		exp_cmd.reg_addr = ra;
		exp_cmd.wdata    = phy_regs[ra];
		check_cmd("read frame fields", phy_cmd, exp_cmd);
		check_flag("read frame preamble and ST", frame_ok, 1'b1);
		check_flag("mdio_oen released at turnaround", oen_release == 7'd46, 1'b1);
	endtask

	task automatic csr_readback();
		run_xfer(1'b0, 1'b0, `SONIC_CSR_CTRL, 6'd4); // CTRL through STATUS
		check_flag("early_done seen before done", early_seen, 1'b1);
		pop_words(4);
		check_word("CTRL readback", got_words[0], ctrl_last);
		check_word("WDATA readback", got_words[1], wdata_last);
		check_word("RDATA readback", got_words[2], rdata_last);
		check_word("STATUS readback", got_words[3], '0);
	endtask

	task automatic full_write_buffer();
		logic [`SONIC_DATA_W-1:0] q [$];
		repeat (`SONIC_FIFO_DEPTH)
			q.push_back($urandom);
		push_words(q);
		@(negedge clk);
		check_flag("user_buffer_full after filling", user_buffer_full, 1'b1);
		run_xfer(1'b1, 1'b1, `SONIC_CSR_WDATA, `SONIC_ADDR_W'(`SONIC_FIFO_DEPTH));
		check_flag("user_buffer_full after write transfer", user_buffer_full, 1'b0);
		wdata_last = q[`SONIC_FIFO_DEPTH-1]; // last write wins
		run_xfer(1'b0, 1'b1, `SONIC_CSR_WDATA, 6'd1);
		pop_words(1);
		check_word("WDATA after fixed write", got_words[0], wdata_last);
	endtask

	task automatic full_read_buffer();
		run_xfer(1'b0, 1'b1, `SONIC_CSR_STATUS, `SONIC_ADDR_W'(`SONIC_FIFO_DEPTH));
		check_flag("data available after filling read buffer", user_data_available, 1'b1);
		pop_words(`SONIC_FIFO_DEPTH);
		foreach (got_words[i])
			check_word($sformatf("STATUS word %0d", i), got_words[i], '0); // idle
		@(negedge clk);
		check_flag("read buffer drained", user_data_available, 1'b0);
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		errors                 = 0;
		checks                 = 0;
		void'($urandom(32'h15f9));
		rst_n                  = 1'b0;
		control_req            = '0;
		control_go             = 1'b0;
		user_read_buffer       = 1'b0;
		user_write_buffer      = 1'b0;
		user_buffer_input_data = '0;
		foreach (phy_regs[i])
			phy_regs[i] = 16'($urandom);
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		reset_state();
		mdio_write_frame();
		mdio_read_frame();
		csr_readback();
		full_write_buffer();
		full_read_buffer();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule : tb_sonic_mdio

//--- sonic_mdio.f
+incdir+hw
hw/sonic_bus_pkg.sv
hw/sonic_mdio_pkg.sv
hw/sonic_user_fifo.sv
hw/sonic_master_ctrl.sv
hw/sonic_mdio_csr.sv
hw/sonic_mdio_shifter.sv
hw/sonic_mdio_top.sv
test/tb_clock.sv
test/tb_mdio_phy.sv
test/tb_sonic_mdio.sv

//--- run_sim.sh
#!/bin/bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -f sonic_mdio.f --top-module tb_sonic_mdio -o sim_sonic_mdio &&
./obj_dir/sim_sonic_mdio | tee /dev/stderr | grep -q "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
